// ==== logic/interconnect_defines.svh ====
`ifndef INTERCONNECT_DEFINES_SVH
`define INTERCONNECT_DEFINES_SVH

// ====================
// message format
// ====================

`define ADDR_BITS 4
`define DATA_BITS 16

// router fan-out and arbiter fan-in
`define NUM_PORTS 16
`define XBAR_PORTS 2

// ====================
// address map
// ====================

`define ADDR_XBAR_IN0 0
`define ADDR_XBAR_CTRL 1
`define ADDR_XBAR_IN1 2
`define ADDR_LOOPBACK 9

`endif

// ==== logic/interconnect_pkg.sv ====
`include "interconnect_defines.svh"

package interconnect_pkg;

  // routing address, also used as the arbiter tag
  typedef logic [`ADDR_BITS-1:0] addr_t;

  // payload
  typedef logic [`DATA_BITS-1:0] data_t;

  // address on top, payload below
  typedef logic [`ADDR_BITS+`DATA_BITS-1:0] packet_t;

  // crossbar setting
  // bit 1 picks the input, bit 0 picks the output
  typedef logic [1:0] xbar_ctrl_t;

  // router or arbiter port number
  typedef logic [$clog2(`NUM_PORTS)-1:0] port_idx_t;

endpackage

// ==== logic/msg_router.sv ====
`include "interconnect_defines.svh"

module msg_router
  import interconnect_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // address-routed input stream
  input  packet_t               in_msg_i,
  input  logic                  in_val_i,
  output logic                  in_rdy_o,

  // one stream per destination, address stripped
  output data_t                 out_msg_o [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] out_val_o,
  input  logic [`NUM_PORTS-1:0] out_rdy_i
);

  packet_t buf_q;
  logic    full_q;
  addr_t   buf_addr;
  data_t   buf_data;
  logic    taken;
  logic    in_acc;

  assign buf_addr = buf_q[`DATA_BITS +: `ADDR_BITS];
  assign buf_data = buf_q[`DATA_BITS-1:0];

  // destination port takes the held packet
  assign taken = full_q && out_rdy_i[buf_addr];

  // free slot, or the slot drains on this same edge
  assign in_rdy_o = !full_q || taken;
  assign in_acc   = in_val_i && in_rdy_o;

  // ====================
  // output steering
  // ====================

  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      out_msg_o[i] = buf_data;
      out_val_o[i] = full_q && (buf_addr == addr_t'(i));
    end
  end

  // ====================
  // one-entry buffer
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (in_acc) begin
      full_q <= 1'b1;
    end else if (taken) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_acc) begin
      buf_q <= in_msg_i;
    end
  end

  // a packet is only ever offered to the port its address names
  a_one_dest: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    $onehot0(out_val_o)
  );

endmodule

// ==== logic/msg_arbiter.sv ====
`include "interconnect_defines.svh"

module msg_arbiter
  import interconnect_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n_i,

  // return streams, one per port
  input  data_t                 in_msg_i [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] in_val_i,
  output logic [`NUM_PORTS-1:0] in_rdy_o,

  // merged stream, tagged with the source port
  output packet_t               out_msg_o,
  output logic                  out_val_o,
  input  logic                  out_rdy_i
);

  packet_t   out_msg_q;
  logic      out_val_q;
  port_idx_t last_q;
  port_idx_t grant_idx;
  logic      grant_vld;
  logic      can_load;
  logic      load;

  // ====================
  // round-robin pick
  // ====================

  // search begins one past the last granted port
  always_comb begin
    port_idx_t cand;
    grant_vld = 1'b0;
    grant_idx = last_q;
    for (int off = 1; off <= `NUM_PORTS; off++) begin
      cand = port_idx_t'(int'(last_q) + off);
      if (!grant_vld && in_val_i[cand]) begin
        grant_vld = 1'b1;
        grant_idx = cand;
      end
    end
  end

  // output register empty or emptied this edge
  assign can_load = !out_val_q || out_rdy_i;
  assign load     = can_load && grant_vld;

  always_comb begin
    in_rdy_o = '0;
    if (load) begin
      in_rdy_o[grant_idx] = 1'b1;
    end
  end

  // ====================
  // output register
  // ====================

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_val_q <= 1'b0;
      last_q    <= port_idx_t'(`NUM_PORTS - 1);
    end else if (load) begin
      out_val_q <= 1'b1;
      last_q    <= grant_idx;
    end else if (out_rdy_i) begin
      out_val_q <= 1'b0;
    end
  end

  // tag goes where the router address was
  always_ff @(posedge clk) begin
    if (load) begin
      out_msg_q <= {addr_t'(grant_idx), in_msg_i[grant_idx]};
    end
  end

  assign out_msg_o = out_msg_q;
  assign out_val_o = out_val_q;

  // a stalled message is held unchanged until it is taken
  a_hold_stalled: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    out_val_o && !out_rdy_i |=> out_val_o && $stable(out_msg_o)
  );

endmodule

// ==== logic/blocking_xbar.sv ====
module blocking_xbar
  import interconnect_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,

  // two inject streams
  input  data_t      in_msg_i [2],
  input  logic [1:0] in_val_i,
  output logic [1:0] in_rdy_o,

  // two return streams
  output data_t      out_msg_o [2],
  output logic [1:0] out_val_o,
  input  logic [1:0] out_rdy_i,

  // setting stream
  input  xbar_ctrl_t ctrl_msg_i,
  input  logic       ctrl_val_i,
  output logic       ctrl_rdy_o
);

  xbar_ctrl_t ctrl_q;
  logic       sel_in;
  logic       sel_out;

  assign sel_in  = ctrl_q[1];
  assign sel_out = ctrl_q[0];

  // ====================
  // datapath
  // ====================

  // one input to one output, the other pair stays blocked
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      out_msg_o[i] = in_msg_i[sel_in];
      out_val_o[i] = (1'(i) == sel_out) && in_val_i[sel_in];
      in_rdy_o[i]  = (1'(i) == sel_in) && out_rdy_i[sel_out];
    end
  end

  // ====================
  // setting register
  // ====================

  // never stalls a setting
  assign ctrl_rdy_o = 1'b1;

  // new setting applies after the accepting edge
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (ctrl_val_i && ctrl_rdy_o) begin
      ctrl_q <= ctrl_msg_i;
    end
  end

  // the blocked output stays quiet whatever the inputs do
  a_blocked_quiet: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    !out_val_o[~sel_out]
  );

endmodule

// ==== logic/interconnect_top.sv ====
`include "interconnect_defines.svh"

module interconnect_top
  import interconnect_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n_i,

  input  packet_t recv_msg_i,
  input  logic    recv_val_i,
  output logic    recv_rdy_o,

  output packet_t send_msg_o,
  output logic    send_val_o,
  input  logic    send_rdy_i
);

  data_t                 router_msg [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] router_val;
  logic [`NUM_PORTS-1:0] router_rdy;

  data_t                 arb_msg [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] arb_val;
  logic [`NUM_PORTS-1:0] arb_rdy;

  data_t                  xbar_in_msg [`XBAR_PORTS];
  logic [`XBAR_PORTS-1:0] xbar_in_val;
  logic [`XBAR_PORTS-1:0] xbar_in_rdy;
  data_t                  xbar_out_msg [`XBAR_PORTS];
  logic [`XBAR_PORTS-1:0] xbar_out_val;
  logic [`XBAR_PORTS-1:0] xbar_out_rdy;
  xbar_ctrl_t             xbar_ctrl_msg;
  logic                   xbar_ctrl_rdy;

  msg_router router0 (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_msg_i  (recv_msg_i),
    .in_val_i  (recv_val_i),
    .in_rdy_o  (recv_rdy_o),
    .out_msg_o (router_msg),
    .out_val_o (router_val),
    .out_rdy_i (router_rdy)
  );

  // ====================
  // address map
  // ====================

  assign xbar_in_msg[0] = router_msg[`ADDR_XBAR_IN0];
  assign xbar_in_msg[1] = router_msg[`ADDR_XBAR_IN1];
  assign xbar_in_val    = {router_val[`ADDR_XBAR_IN1], router_val[`ADDR_XBAR_IN0]};

  // only the low data bits carry the setting
  assign xbar_ctrl_msg = router_msg[`ADDR_XBAR_CTRL][$bits(xbar_ctrl_t)-1:0];

  // unmapped router ports never accept, so a stray message stalls input
  always_comb begin
    router_rdy                  = '0;
    router_rdy[`ADDR_XBAR_IN0]  = xbar_in_rdy[0];
    router_rdy[`ADDR_XBAR_CTRL] = xbar_ctrl_rdy;
    router_rdy[`ADDR_XBAR_IN1]  = xbar_in_rdy[1];
    router_rdy[`ADDR_LOOPBACK]  = arb_rdy[`ADDR_LOOPBACK];
  end

  // return ports mirror the inject addresses
  always_comb begin
    for (int i = 0; i < `NUM_PORTS; i++) begin
      arb_msg[i] = '0;
    end
    arb_val                    = '0;
    arb_msg[`ADDR_XBAR_IN0]    = xbar_out_msg[0];
    arb_val[`ADDR_XBAR_IN0]    = xbar_out_val[0];
    arb_msg[`ADDR_XBAR_IN1]    = xbar_out_msg[1];
    arb_val[`ADDR_XBAR_IN1]    = xbar_out_val[1];
    // loopback
    arb_msg[`ADDR_LOOPBACK]    = router_msg[`ADDR_LOOPBACK];
    arb_val[`ADDR_LOOPBACK]    = router_val[`ADDR_LOOPBACK];
  end

  assign xbar_out_rdy = {arb_rdy[`ADDR_XBAR_IN1], arb_rdy[`ADDR_XBAR_IN0]};

  blocking_xbar xbar0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .in_msg_i   (xbar_in_msg),
    .in_val_i   (xbar_in_val),
    .in_rdy_o   (xbar_in_rdy),
    .out_msg_o  (xbar_out_msg),
    .out_val_o  (xbar_out_val),
    .out_rdy_i  (xbar_out_rdy),
    .ctrl_msg_i (xbar_ctrl_msg),
    .ctrl_val_i (router_val[`ADDR_XBAR_CTRL]),
    .ctrl_rdy_o (xbar_ctrl_rdy)
  );

  msg_arbiter arbiter0 (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .in_msg_i  (arb_msg),
    .in_val_i  (arb_val),
    .in_rdy_o  (arb_rdy),
    .out_msg_o (send_msg_o),
    .out_val_o (send_val_o),
    .out_rdy_i (send_rdy_i)
  );

endmodule

// ==== sim/interconnect_tb.sv ====
`include "interconnect_defines.svh"

module interconnect_tb
  import interconnect_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 100;

  // arbiter ports that return each path
  localparam addr_t XBAR_OUT0_TAG = addr_t'(0);
  localparam addr_t XBAR_OUT1_TAG = addr_t'(2);
  localparam addr_t LOOPBACK_TAG  = addr_t'(9);

  logic    clk;
  logic    rst_n_i;
  packet_t recv_msg_i;
  logic    recv_val_i;
  logic    recv_rdy_o;
  packet_t send_msg_o;
  logic    send_val_o;
  logic    send_rdy_i;

  int         seed;
  int         cycle;
  string      test_name;
  xbar_ctrl_t setting;
  packet_t    exp_q [$];
  int         edge_q [$];
  packet_t    exp_pkt;
  int         exp_edge;
  logic       prev_stall;
  packet_t    prev_msg;
  packet_t    pkt;
  int         accepted;
  logic       stalled;

  interconnect_top dut0 (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .recv_msg_i (recv_msg_i),
    .recv_val_i (recv_val_i),
    .recv_rdy_o (recv_rdy_o),
    .send_msg_o (send_msg_o),
    .send_val_o (send_val_o),
    .send_rdy_i (send_rdy_i)
  );

  always #4 clk = ~clk;

  // count of rising edges seen by the falling-edge monitor
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ====================
  // reference model
  // ====================

  function automatic packet_t expected_packet(input packet_t sent, input xbar_ctrl_t ctrl);
    addr_t addr;
    data_t data;
    addr_t in_addr;
    addr_t out_tag;
    addr    = sent[`DATA_BITS +: `ADDR_BITS];
    data    = sent[`DATA_BITS-1:0];
    in_addr = ctrl[1] ? addr_t'(`ADDR_XBAR_IN1) : addr_t'(`ADDR_XBAR_IN0);
    out_tag = ctrl[0] ? XBAR_OUT1_TAG : XBAR_OUT0_TAG;
    if (addr == addr_t'(`ADDR_LOOPBACK)) begin
      return {LOOPBACK_TAG, data};
    end else if (addr == in_addr) begin
      return {out_tag, data};
    end
    // unmapped or blocked address is never sent
    return '0;
  endfunction

  // ====================
  // checks
  // ====================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_packet(input string name, input packet_t exp, input packet_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      abort_run($sformatf("FAILED %s latency: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // output monitor samples mid-cycle where everything has settled
  always @(negedge clk) begin
    if (rst_n_i) begin
      if (prev_stall) begin
        check_packet({test_name, " held message"}, prev_msg, send_msg_o);
        check_bit({test_name, " held valid"}, 1'b1, send_val_o);
      end
      if (send_val_o && send_rdy_i) begin
        if (exp_q.size() == 0) begin
          abort_run({test_name, ": an output message arrived that was never expected"});
        end else begin
          exp_pkt  = exp_q.pop_front();
          exp_edge = edge_q.pop_front();
          check_packet(test_name, exp_pkt, send_msg_o);
          if (exp_edge >= 0) begin
            check_latency(test_name, 2, cycle + 1 - exp_edge);
          end
        end
      end
      prev_stall = send_val_o && !send_rdy_i;
      prev_msg   = send_msg_o;
    end
  end

  // ====================
  // stimulus helpers
  // ====================

  task automatic wait_accept(input string name);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!recv_rdy_o) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run({name, ": the input stream never became ready"});
      end
      @(negedge clk);
    end
  endtask

  task automatic push_expected(input packet_t sent, input logic timed);
    exp_q.push_back(expected_packet(sent, setting));
    // transfer happens on the next rising edge
    edge_q.push_back(timed ? cycle + 1 : -1);
  endtask

  // called and returns 1 ns after a rising edge
  task automatic send_packet(input string name, input packet_t msg,
                             input logic expect_out, input logic timed);
    recv_msg_i = msg;
    recv_val_i = 1'b1;
    wait_accept(name);
    if (expect_out) begin
      push_expected(msg, timed);
    end
    @(posedge clk);
    #1;
    recv_val_i = 1'b0;
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run({name, ": expected messages never came out"});
      end
    end
    @(posedge clk);
    #1;
  endtask

  // ====================
  // test sequence
  // ====================

  initial begin
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    recv_msg_i = '0;
    recv_val_i = 1'b0;
    send_rdy_i = 1'b1;
    seed       = 32'h695917bc;
    cycle      = 0;
    setting    = '0;
    prev_stall = 1'b0;
    prev_msg   = '0;
    test_name  = "reset";

    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    @(negedge clk);
    check_bit("reset send_val_o", 1'b0, send_val_o);
    check_bit("reset recv_rdy_o", 1'b1, recv_rdy_o);
    @(posedge clk);
    #1;

    test_name = "loopback";
    for (int i = 0; i < 20; i++) begin
      pkt = {addr_t'(`ADDR_LOOPBACK), data_t'($random(seed))};
      send_packet(test_name, pkt, 1'b1, 1'b1);
    end
    wait_drain(test_name);

    test_name = "default path";
    for (int i = 0; i < 5; i++) begin
      pkt = {addr_t'(`ADDR_XBAR_IN0), data_t'($random(seed))};
      send_packet(test_name, pkt, 1'b1, 1'b0);
    end
    wait_drain(test_name);

    for (int s = 0; s < 4; s++) begin
      test_name = $sformatf("xbar setting %0d", s);
      pkt = {addr_t'(`ADDR_XBAR_CTRL), data_t'($random(seed))};
      pkt[1:0] = xbar_ctrl_t'(s);
      send_packet(test_name, pkt, 1'b0, 1'b0);
      setting = xbar_ctrl_t'(s);
      pkt = {setting[1] ? addr_t'(`ADDR_XBAR_IN1) : addr_t'(`ADDR_XBAR_IN0),
             data_t'($random(seed))};
      send_packet(test_name, pkt, 1'b1, 1'b0);
      wait_drain(test_name);
    end

    // fill arbiter register and router buffer until the input stalls
    test_name  = "back-pressure";
    send_rdy_i = 1'b0;
    accepted   = 0;
    stalled    = 1'b0;
    while (!stalled) begin
      pkt = {addr_t'(`ADDR_LOOPBACK), data_t'($random(seed))};
      recv_msg_i = pkt;
      recv_val_i = 1'b1;
      @(negedge clk);
      if (recv_rdy_o) begin
        push_expected(pkt, 1'b0);
        accepted++;
        if (accepted > 8) begin
          abort_run("back-pressure: the input stream never stalled");
        end
        @(posedge clk);
        #1;
      end else begin
        stalled = 1'b1;
      end
    end
    @(posedge clk);
    #1;
    repeat (6) @(posedge clk);
    #1;
    send_rdy_i = 1'b1;
    // the stalled message is still on the input
    wait_accept(test_name);
    push_expected(pkt, 1'b0);
    @(posedge clk);
    #1;
    recv_val_i = 1'b0;
    wait_drain(test_name);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+logic
logic/interconnect_pkg.sv
logic/msg_router.sv
logic/msg_arbiter.sv
logic/blocking_xbar.sv
logic/interconnect_top.sv
sim/interconnect_tb.sv

// ==== Makefile ====
# Verilator build and run for the interconnect testbench

VERILATOR ?= verilator
TOP       ?= interconnect_tb
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILE_LIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILE_LIST) $(SRCS) logic/interconnect_defines.svh
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only if the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)
